// File: hdl/emesh_pkg.sv
//######################################################################
// mesh packet layout shared by the SPI register block and testbench
// import for field widths, packet type and field bit offsets
//######################################################################
`default_nettype none

package emesh_pkg;

   localparam int aw = 32;                // address width
   localparam int pw = 2*aw + 40;         // packet width, 104

   typedef logic [aw-1:0] addr_t;         // address or data word
   typedef logic [4:0]    ctrlmode_t;     // control mode field
   typedef logic [1:0]    datamode_t;     // data size field
   typedef logic [pw-1:0] packet_t;       // full packet vector

   //###################################################################
   // field offsets, lsb of each field
   //###################################################################
   localparam int pkt_write_bit    = 0;   // 1 = write, 0 = read
   localparam int pkt_datamode_lsb = 1;   // bits 2:1
   localparam int pkt_ctrlmode_lsb = 3;   // bits 7:3
   localparam int pkt_dstaddr_lsb  = 8;   // bits 39:8
   localparam int pkt_data_lsb     = 40;  // bits 71:40
   localparam int pkt_srcaddr_lsb  = 72;  // bits 103:72

endpackage

`default_nettype wire

// File: hdl/spi_pkg.sv
//######################################################################
// SPI master register map, bit positions, FIFO sizing and FSM states
//######################################################################
`default_nettype none

package spi_pkg;

   // register offsets, decoded from address bits 5:0
   localparam logic [5:0] spi_config = 6'h00;
   localparam logic [5:0] spi_status = 6'h04;
   localparam logic [5:0] spi_clkdiv = 6'h08;
   localparam logic [5:0] spi_tx     = 6'h10;
   localparam logic [5:0] spi_rx0    = 6'h20;  // rx bits 31:0
   localparam logic [5:0] spi_rx1    = 6'h24;  // rx bits 63:32

   typedef logic [7:0]  byte_t;
   typedef logic [63:0] rxword_t;              // rx accumulator

   localparam byte_t clkdiv_default = 8'd1;    // half period = 2 clk

   // tx fifo sizing
   localparam int fifo_depth = 8;
   localparam int fifo_aw    = 3;              // address bits into storage
   typedef logic [3:0] fifo_ptr_t;             // one extra wrap bit

   // config bits
   localparam int cfg_disable  = 0;            // 1 stops new transfers
   localparam int cfg_cpol     = 2;
   localparam int cfg_cpha     = 3;
   localparam int cfg_lsbfirst = 4;

   // status bits
   localparam int st_rx_done   = 0;            // sticky
   localparam int st_busy      = 1;            // live, fsm not idle
   localparam int st_prog_full = 2;            // live, fifo level >= 4
   localparam int st_overflow  = 3;            // sticky

   typedef enum logic [1:0] {idle, setup, data, hold} spi_state_t;

   localparam logic [31:0] rd_bad_value = 32'hDEADBEEF; // unmapped read

endpackage

`default_nettype wire

// File: hdl/spi_tx_fifo.sv
//######################################################################
// transmit byte FIFO, fall-through read side feeds the shift engine
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module spi_tx_fifo
  (
   input  wire             clk,
   input  wire             nreset,
   input  wire             tx_push,
   input  spi_pkg::byte_t  tx_byte,
   input  wire             fifo_pop,
   output spi_pkg::byte_t  fifo_data,
   output logic            fifo_empty,
   output logic            fifo_prog_full,
   output logic            fifo_overflow
   );

   import spi_pkg::*;

   byte_t     mem [fifo_depth];
   fifo_ptr_t wr_ptr;
   fifo_ptr_t rd_ptr;
   fifo_ptr_t level;
   logic      full;
   logic      push_ok;

   assign level          = wr_ptr - rd_ptr;   // wrap bit makes this exact
   assign full           = (level == fifo_ptr_t'(fifo_depth));
   assign fifo_empty     = (wr_ptr == rd_ptr);
   assign fifo_prog_full = (level >= fifo_ptr_t'(fifo_depth/2));
   assign push_ok        = tx_push & ~full;
   assign fifo_overflow  = tx_push & full;   // push dropped

   // storage
   always_ff @(posedge clk)
      if (push_ok)
         mem[wr_ptr[fifo_aw-1:0]] <= tx_byte;

   assign fifo_data = mem[rd_ptr[fifo_aw-1:0]]; // head of queue

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         if (push_ok)
            wr_ptr <= wr_ptr + 1'b1;
         if (fifo_pop & ~fifo_empty)
            rd_ptr <= rd_ptr + 1'b1;         // ignore pop on empty
      end

endmodule

`default_nettype wire

// File: hdl/spi_master_io.sv
//######################################################################
// SPI shift engine, pulls bytes from the tx FIFO and drives the pins
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module spi_master_io
  (
   input  wire                  clk,
   input  wire                  nreset,
   input  wire                  spi_en,
   input  wire                  cpol,
   input  wire                  cpha,
   input  wire                  lsbfirst,
   input  spi_pkg::byte_t       clkdiv,
   input  wire                  fifo_empty,
   input  spi_pkg::byte_t       fifo_data,
   output logic                 fifo_pop,
   output spi_pkg::spi_state_t  spi_state,
   output logic                 rx_access,
   output spi_pkg::byte_t       rx_byte,
   output logic                 sclk,
   output logic                 mosi,
   output logic                 ss,
   input  wire                  miso
   );

   import spi_pkg::*;

   spi_state_t state;
   spi_state_t state_nxt;
   byte_t      div_cnt;
   logic       tick;          // end of a half period
   logic [3:0] half_cnt;      // half periods within data
   logic       phase;         // sclk away from idle level
   logic       start;
   logic       sample;
   logic       shift;
   byte_t      tx_sr;
   byte_t      rx_sr;

   assign tick   = (state != idle) & (div_cnt == '0);
   assign start  = spi_en & ~fifo_empty & ((state == idle) | ((state == hold) & tick));
   // even half_cnt ends on leading edge, odd on trailing edge
   assign sample = tick & (state == data) & (half_cnt[0] == cpha);
   assign shift  = tick & (state == data) & (half_cnt[0] != cpha) &
                   ~(cpha & (half_cnt == '0));   // cpha 1 keeps first bit

   //###################################################################
   // state machine
   //###################################################################
   always_comb
   begin
      state_nxt = state;
      case (state)
         idle  : if (start) state_nxt = setup;
         setup : if (tick) state_nxt = data;
         data  : if (tick && half_cnt == 4'd15) state_nxt = hold;
         hold  : if (tick) state_nxt = start ? setup : idle; // back to back
         default : state_nxt = idle;
      endcase
   end

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
      begin
         state    <= idle;
         div_cnt  <= '0;
         half_cnt <= '0;
         phase    <= 1'b0;
      end
      else
      begin
         state <= state_nxt;
         if (state == idle || tick)
            div_cnt <= clkdiv;                // reload each half period
         else
            div_cnt <= div_cnt - 1'b1;
         if (state != data)
            half_cnt <= '0;
         else if (tick)
            half_cnt <= half_cnt + 1'b1;
         if (tick && state == data)
            phase <= ~phase;                  // 16 toggles, ends at 0
      end

   //###################################################################
   // data path
   //###################################################################
   always_ff @(posedge clk)
   begin
      if (start)
         tx_sr <= fifo_data;                  // first bit out at setup
      else if (shift)
         tx_sr <= lsbfirst ? {1'b0, tx_sr[7:1]} : {tx_sr[6:0], 1'b0};
      if (sample)
         rx_sr <= lsbfirst ? {miso, rx_sr[7:1]} : {rx_sr[6:0], miso};
   end

   assign fifo_pop  = start;
   assign spi_state = state;
   assign rx_access = (state == hold) & tick; // byte complete
   assign rx_byte   = rx_sr;
   assign sclk      = cpol ^ phase;
   assign mosi      = lsbfirst ? tx_sr[0] : tx_sr[7];
   assign ss        = (state == idle);       // active low select

endmodule

`default_nettype wire

// File: hdl/spi_master_regs.sv
//######################################################################
// SPI master control registers, decodes mesh packets from the core
// and returns read replies one cycle after the request
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module spi_master_regs
  (
   input  wire                  clk,
   input  wire                  nreset,
   input  wire                  access_in,      // request strobe
   input  emesh_pkg::packet_t   packet_in,
   output logic                 access_out,     // reply strobe
   output emesh_pkg::packet_t   packet_out,
   output logic                 spi_en,
   output logic                 cpol,
   output logic                 cpha,
   output logic                 lsbfirst,
   output spi_pkg::byte_t       clkdiv,
   output logic                 tx_push,
   output spi_pkg::byte_t       tx_byte,
   input  wire                  fifo_prog_full,
   input  wire                  fifo_overflow,
   input  spi_pkg::spi_state_t  spi_state,
   input  wire                  rx_access,
   input  spi_pkg::byte_t       rx_byte
   );

   import emesh_pkg::*;
   import spi_pkg::*;

   logic       write_in;
   datamode_t  datamode_in;
   ctrlmode_t  ctrlmode_in;
   addr_t      dstaddr_in;
   addr_t      srcaddr_in;
   addr_t      data_in;
   logic       reg_write;
   logic       reg_read;
   logic [5:0] reg_addr;
   logic       config_write;
   logic       status_write;
   logic       clkdiv_write;
   byte_t      config_reg;
   byte_t      status_reg;
   byte_t      status_nxt;
   rxword_t    rx_reg;
   addr_t      reg_rdata;
   addr_t      dstaddr_out;
   ctrlmode_t  ctrlmode_out;
   datamode_t  datamode_out;

   //###################################################################
   // packet decode
   //###################################################################
   assign write_in    = packet_in[pkt_write_bit];
   assign datamode_in = packet_in[pkt_datamode_lsb +: $bits(datamode_t)];
   assign ctrlmode_in = packet_in[pkt_ctrlmode_lsb +: $bits(ctrlmode_t)];
   assign dstaddr_in  = packet_in[pkt_dstaddr_lsb +: aw];
   assign srcaddr_in  = packet_in[pkt_srcaddr_lsb +: aw];
   assign data_in     = packet_in[pkt_data_lsb +: aw];

   assign reg_write    = access_in & write_in;
   assign reg_read     = access_in & ~write_in;
   assign reg_addr     = dstaddr_in[5:0];     // only low bits decoded
   assign config_write = reg_write & (reg_addr == spi_config);
   assign status_write = reg_write & (reg_addr == spi_status);
   assign clkdiv_write = reg_write & (reg_addr == spi_clkdiv);

   // tx writes go straight to the fifo
   assign tx_push = reg_write & (reg_addr == spi_tx);
   assign tx_byte = data_in[7:0];

   //###################################################################
   // config and clkdiv
   //###################################################################
   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         config_reg <= '0;                    // enabled, mode 0, msb first
      else if (config_write)
         config_reg <= data_in[7:0];

   assign spi_en   = ~config_reg[cfg_disable];
   assign cpol     = config_reg[cfg_cpol];
   assign cpha     = config_reg[cfg_cpha];
   assign lsbfirst = config_reg[cfg_lsbfirst];

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         clkdiv <= clkdiv_default;
      else if (clkdiv_write)
         clkdiv <= data_in[7:0];

   //###################################################################
   // status, write wins over live update
   //###################################################################
   always_comb
   begin
      status_nxt               = '0;
      status_nxt[st_rx_done]   = rx_access | status_reg[st_rx_done];
      status_nxt[st_busy]      = (spi_state != idle);
      status_nxt[st_prog_full] = fifo_prog_full;
      status_nxt[st_overflow]  = fifo_overflow | status_reg[st_overflow];
   end

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         status_reg <= '0;
      else if (status_write)
         status_reg <= data_in[7:0];          // clears sticky bits
      else
         status_reg <= status_nxt;

   // rx bytes shift in from the low end
   always_ff @(posedge clk)
      if (rx_access)
         rx_reg <= {rx_reg[55:0], rx_byte};

   //###################################################################
   // read reply
   //###################################################################
   always_ff @(posedge clk)
      if (reg_read)
      begin
         case (reg_addr)
            spi_config : reg_rdata <= addr_t'(config_reg);
            spi_status : reg_rdata <= addr_t'(status_reg);
            spi_clkdiv : reg_rdata <= addr_t'(clkdiv);
            spi_rx0    : reg_rdata <= rx_reg[31:0];
            spi_rx1    : reg_rdata <= rx_reg[63:32];
            default    : reg_rdata <= rd_bad_value;
         endcase
         dstaddr_out  <= srcaddr_in;          // reply goes back to sender
         ctrlmode_out <= ctrlmode_in;
         datamode_out <= datamode_in;
      end

   always_ff @(posedge clk or negedge nreset)
      if (!nreset)
         access_out <= 1'b0;
      else
         access_out <= reg_read;

   always_comb
   begin
      packet_out                                         = '0; // srcaddr 0
      packet_out[pkt_write_bit]                          = 1'b1;
      packet_out[pkt_datamode_lsb +: $bits(datamode_t)]  = datamode_out;
      packet_out[pkt_ctrlmode_lsb +: $bits(ctrlmode_t)]  = ctrlmode_out;
      packet_out[pkt_dstaddr_lsb +: aw]                  = dstaddr_out;
      packet_out[pkt_data_lsb +: aw]                     = reg_rdata;
   end

endmodule

`default_nettype wire

// File: hdl/spi_master.sv
//######################################################################
// SPI master top, mesh packet port on one side and SPI pins on the other
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module spi_master
  (
   input  wire                 clk,
   input  wire                 nreset,
   input  wire                 access_in,
   input  emesh_pkg::packet_t  packet_in,
   output logic                access_out,
   output emesh_pkg::packet_t  packet_out,
   output logic                sclk,
   output logic                mosi,
   output logic                ss,
   input  wire                 miso
   );

   import spi_pkg::*;

   // regs to fifo
   logic       tx_push;
   byte_t      tx_byte;
   logic       fifo_prog_full;
   logic       fifo_overflow;
   // fifo to shift engine
   logic       fifo_empty;
   byte_t      fifo_data;
   logic       fifo_pop;
   // regs and shift engine
   logic       spi_en;
   logic       cpol;
   logic       cpha;
   logic       lsbfirst;
   byte_t      clkdiv;
   spi_state_t spi_state;
   logic       rx_access;
   byte_t      rx_byte;

   spi_master_regs u_regs (.clk, .nreset, .access_in, .packet_in, .access_out,
                           .packet_out, .spi_en, .cpol, .cpha, .lsbfirst, .clkdiv,
                           .tx_push, .tx_byte, .fifo_prog_full, .fifo_overflow,
                           .spi_state, .rx_access, .rx_byte);

   spi_tx_fifo u_fifo (.clk, .nreset, .tx_push, .tx_byte, .fifo_pop, .fifo_data,
                       .fifo_empty, .fifo_prog_full, .fifo_overflow);

   spi_master_io u_io (.clk, .nreset, .spi_en, .cpol, .cpha, .lsbfirst, .clkdiv,
                       .fifo_empty, .fifo_data, .fifo_pop, .spi_state, .rx_access,
                       .rx_byte, .sclk, .mosi, .ss, .miso);

endmodule

`default_nettype wire

// File: verif/spi_master_asserts.sv
//######################################################################
// SPI pin and reply timing rules checked inside the bound SPI master top
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module spi_master_asserts
  (
   input wire                      clk,
   input wire                      nreset,
   input wire                      access_in,
   input wire emesh_pkg::packet_t  packet_in,
   input wire                      access_out,
   input wire                      sclk,
   input wire                      ss,
   input wire                      cpol
   );

   import emesh_pkg::*;

   int   assert_errors = 0;    // read by the testbench at the end
   logic read_req;

   assign read_req = access_in & ~packet_in[pkt_write_bit];

   // reply strobe one cycle behind a read and at no other time
   reply_timing: assert property (@(posedge clk) disable iff (!nreset)
                                  access_out == $past(read_req))
      else
      begin
         assert_errors++;
         $error("reply strobe not one cycle after read");
      end

   sclk_idle: assert property (@(posedge clk) disable iff (!nreset)
                               ss |-> (sclk == cpol))     // idle clock level
      else
      begin
         assert_errors++;
         $error("sclk differs from cpol with ss high");
      end

   ss_reset: assert property (@(posedge clk) !nreset |-> ss)
      else
      begin
         assert_errors++;
         $error("ss low during reset");
      end

endmodule

`default_nettype wire

// File: verif/spi_master_tb.sv
//######################################################################
// trace-driven testbench for the SPI master with mosi looped back to miso
// reads verif/spi_master_trace.txt, run from the project root
//######################################################################
`timescale 1ns/1ps
`default_nettype none

module spi_master_tb;

   import emesh_pkg::*;
   import spi_pkg::*;

   localparam int        max_cmds     = 128;            // trace capacity in lines
   localparam int        max_poll     = 4000;           // reads per poll before giving up
   localparam int        byte_cyc     = (16 + 2) * 256; // worst byte at clkdiv 255
   localparam addr_t     dev_base     = 32'h8120_0000;  // trace offsets land here
   localparam addr_t     src_addr     = 32'h8A40_0000;  // replies must come back here
   localparam ctrlmode_t req_ctrlmode = 5'h0B;          // echoed in every reply
   localparam datamode_t req_datamode = 2'b10;          // word access

   logic    clk;
   logic    nreset;
   logic    access_in;
   packet_t packet_in;
   logic    access_out;
   packet_t packet_out;
   logic    sclk;
   logic    mosi;
   logic    ss;

   addr_t   trace_mem [4*max_cmds];   // op, addr, arg1, arg2 per line
   int      n_cmds = 0;
   int      errors = 0;
   int      checks = 0;

   spi_master u_spi_master (.clk, .nreset, .access_in, .packet_in, .access_out,
                            .packet_out, .sclk, .mosi, .ss,
                            .miso(mosi));  // loopback

   bind spi_master spi_master_asserts u_asserts (.clk(clk), .nreset(nreset),
                                                 .access_in(access_in),
                                                 .packet_in(packet_in),
                                                 .access_out(access_out),
                                                 .sclk(sclk), .ss(ss), .cpol(cpol));

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;                  // 100 ns period
   end

   //###################################################################
   // helpers
   //###################################################################
   function automatic packet_t make_packet(input logic write, input addr_t dst,
                                           input addr_t wdata);
      packet_t p;
      p                                        = '0;
      p[pkt_write_bit]                         = write;
      p[pkt_datamode_lsb +: $bits(datamode_t)] = req_datamode;
      p[pkt_ctrlmode_lsb +: $bits(ctrlmode_t)] = req_ctrlmode;
      p[pkt_dstaddr_lsb +: aw]                 = dst;
      p[pkt_data_lsb +: aw]                    = wdata;
      p[pkt_srcaddr_lsb +: aw]                 = src_addr;
      return p;
   endfunction

   task automatic compare(input string name, input addr_t got, input addr_t exp);
      checks++;
      if (got !== exp)
      begin
         errors++;
         $display("FAIL %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic write_reg(input addr_t addr, input addr_t wdata);
      @(negedge clk);
      access_in = 1'b1;
      packet_in = make_packet(1'b1, dev_base | addr, wdata);
      @(negedge clk);
      access_in = 1'b0;                        // single cycle strobe
      packet_in = '0;
   endtask

   // reply is due exactly one cycle after the request
   task automatic read_reg(input addr_t addr, output addr_t rdata, output addr_t rdst);
      @(negedge clk);
      access_in = 1'b1;
      packet_in = make_packet(1'b0, dev_base | addr, '0);
      @(negedge clk);
      access_in = 1'b0;
      packet_in = '0;
      compare("access_out", addr_t'(access_out), 32'h1);
      compare("write_out", addr_t'(packet_out[pkt_write_bit]), 32'h1);
      compare("datamode_out", addr_t'(packet_out[pkt_datamode_lsb +: $bits(datamode_t)]),
              addr_t'(req_datamode));
      compare("ctrlmode_out", addr_t'(packet_out[pkt_ctrlmode_lsb +: $bits(ctrlmode_t)]),
              addr_t'(req_ctrlmode));
      rdata = packet_out[pkt_data_lsb +: aw];
      rdst  = packet_out[pkt_dstaddr_lsb +: aw];
   endtask

   task automatic poll_reg(input addr_t addr, input addr_t mask, input addr_t value);
      addr_t rdata;
      addr_t rdst;
      int    tries;
      logic  hit;
      tries = 0;
      hit   = 1'b0;
      while (!hit && tries < max_poll)
      begin
         read_reg(addr, rdata, rdst);
         hit = ((rdata & mask) === value);
         tries++;
      end
      if (!hit)
      begin
         errors++;
         $display("poll of address %h gave up after %0d reads, last data %h",
                  addr, tries, rdata);
      end
   endtask

   //###################################################################
   // watchdog sized from the trace length
   //###################################################################
   initial
   begin
      wait (n_cmds > 0);
      repeat (n_cmds * byte_cyc * fifo_depth + 1000) @(posedge clk);
      $display("watchdog expired, trace did not finish in time");
      $display("Test failed");
      $finish;
   end

   //###################################################################
   // trace player
   //###################################################################
   initial
   begin
      int    pc;
      int    total;
      logic  running;
      addr_t op;
      addr_t addr;
      addr_t arg1;
      addr_t arg2;
      addr_t rdata;
      addr_t rdst;

      nreset    = 1'b0;
      access_in = 1'b0;
      packet_in = '0;
      $readmemh("verif/spi_master_trace.txt", trace_mem);
      while (n_cmds < max_cmds - 1 && trace_mem[4*n_cmds] !== 32'h0)
         n_cmds++;
      n_cmds++;                                // count the end line too

      repeat (4) @(negedge clk);               // reset for 4 cycles
      nreset = 1'b1;

      pc      = 0;
      running = 1'b1;
      while (running)
      begin
         op   = trace_mem[4*pc];
         addr = trace_mem[4*pc + 1];
         arg1 = trace_mem[4*pc + 2];
         arg2 = trace_mem[4*pc + 3];
         case (op)
            32'h0 : running = 1'b0;            // end of trace
            32'h1 : write_reg(addr, arg1);
            32'h2 :
            begin
               read_reg(addr, rdata, rdst);
               compare("rdata", rdata, arg1);
               compare("dstaddr", rdst, src_addr);
            end
            32'h3 : poll_reg(addr, arg1, arg2); // arg1 mask, arg2 value
            default :
            begin
               errors++;
               $display("unknown trace command %h on entry %0d", op, pc);
               running = 1'b0;
            end
         endcase
         pc++;
         if (running && pc >= max_cmds)
         begin
            errors++;
            $display("trace has no end command");
            running = 1'b0;
         end
      end

      repeat (4) @(negedge clk);
      total = errors + u_spi_master.u_asserts.assert_errors;
      $display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
               u_spi_master.u_asserts.assert_errors);
      if (total == 0)
         $display("Test passed");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/spi_master_trace.txt
// columns: op address arg1 arg2, all hex, address is a register offset
// op 1 write addr data, 2 read addr expect, 3 poll addr mask value, 0 end
// reset values and an unmapped address
2 00000000 00000000 00000000
2 00000008 00000001 00000000
2 00000004 00000000 00000000
2 0000000C DEADBEEF 00000000
// config and clkdiv read back
1 00000008 00000003 00000000
2 00000008 00000003 00000000
1 00000000 0000001C 00000000
2 00000000 0000001C 00000000
1 00000000 00000000 00000000
// msb first loopback, 8 bytes, wait for rx_done with busy clear
1 00000010 000000A1 00000000
1 00000010 000000B2 00000000
1 00000010 000000C3 00000000
1 00000010 000000D4 00000000
1 00000010 000000E5 00000000
1 00000010 000000F6 00000000
1 00000010 00000007 00000000
1 00000010 00000018 00000000
3 00000004 00000003 00000001
2 00000024 A1B2C3D4 00000000
2 00000020 E5F60718 00000000
// status write of 0 clears rx_done
1 00000004 00000000 00000000
2 00000004 00000000 00000000
// remaining cpol, cpha, lsbfirst modes, one byte each
1 00000000 00000004 00000000
1 00000010 000000C5 00000000
3 00000020 FFFFFFFF F60718C5
1 00000000 00000008 00000000
1 00000010 00000096 00000000
3 00000020 FFFFFFFF 0718C596
1 00000000 0000000C 00000000
1 00000010 0000002B 00000000
3 00000020 FFFFFFFF 18C5962B
1 00000000 00000010 00000000
1 00000010 000000E1 00000000
3 00000020 FFFFFFFF C5962BE1
1 00000000 00000014 00000000
1 00000010 0000004D 00000000
3 00000020 FFFFFFFF 962BE14D
1 00000000 00000018 00000000
1 00000010 000000B8 00000000
3 00000020 FFFFFFFF 2BE14DB8
1 00000000 0000001C 00000000
1 00000010 00000017 00000000
3 00000020 FFFFFFFF E14DB817
// disabled engine, 9 pushes overflow the FIFO
1 00000000 00000001 00000000
1 00000004 00000000 00000000
1 00000010 00000010 00000000
1 00000010 00000021 00000000
1 00000010 00000032 00000000
1 00000010 00000043 00000000
1 00000010 00000054 00000000
1 00000010 00000065 00000000
1 00000010 00000076 00000000
1 00000010 00000087 00000000
1 00000010 00000098 00000000
2 00000004 0000000C 00000000
// enable and drain, ninth byte was dropped
1 00000000 00000000 00000000
3 00000004 00000003 00000001
2 00000004 00000009 00000000
2 00000024 10213243 00000000
2 00000020 54657687 00000000
0 00000000 00000000 00000000

// File: spi_master.f
hdl/emesh_pkg.sv
hdl/spi_pkg.sv
hdl/spi_tx_fifo.sv
hdl/spi_master_io.sv
hdl/spi_master_regs.sv
hdl/spi_master.sv
verif/spi_master_asserts.sv
verif/spi_master_tb.sv

// File: Bender.yml
package:
  name: spi_master

sources:
  - files:
      - hdl/emesh_pkg.sv
      - hdl/spi_pkg.sv
      - hdl/spi_tx_fifo.sv
      - hdl/spi_master_io.sv
      - hdl/spi_master_regs.sv
      - hdl/spi_master.sv
  - target: simulation
    files:
      - verif/spi_master_asserts.sv
      - verif/spi_master_tb.sv
